// ==== hdl/proc_ctrl_defs.svh ====
// shared widths and instruction encodings for the pipeline control unit
`ifndef PROC_CTRL_DEFS_SVH
`define PROC_CTRL_DEFS_SVH

// --------------------------------------------------
// widths
`define INST_W        32
`define REG_ADDR_W    5

// major opcodes
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_LOAD      7'b0000011
`define OPC_BRANCH    7'b1100011
`define OPC_SYSTEM    7'b1110011

// funct3 per kept operation
`define F3_ADD_SUB    3'b000
`define F3_SLL        3'b001
`define F3_SLT        3'b010
`define F3_SLTU       3'b011
`define F3_XOR        3'b100
`define F3_SRL_SRA    3'b101
`define F3_OR         3'b110
`define F3_AND        3'b111
`define F3_ADDI       3'b000
`define F3_LW         3'b010
`define F3_BEQ        3'b000
`define F3_BNE        3'b001
`define F3_CSRRW      3'b001
`define F3_CSRRS      3'b010

// funct7, alt selects sub and sra
`define F7_BASE       7'b0000000
`define F7_ALT        7'b0100000

// manager CSRs
`define CSR_PROC2MNGR 12'h7c0
`define CSR_MNGR2PROC 12'hfc0

// canonical nop, addi x0, x0, 0
`define INST_NOP      32'h00000013

`endif

// ==== hdl/proc_ctrl_pkg.sv ====
// control field types shared by the decoder, stage registers and hazard unit
package proc_ctrl_pkg;

  // --------------------------------------------------
  // X stage ALU function
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_slt  = 4'd5,
    alu_sltu = 4'd6,
    alu_sra  = 4'd7,
    alu_srl  = 4'd8,
    alu_sll  = 4'd9,
    // pass operand 0 or operand 1 straight through
    alu_cp0  = 4'd10,
    alu_cp1  = 4'd11
  } alu_fn_e;

  // immediate format for the D stage immediate generator
  typedef enum logic [2:0] {
    imm_i = 3'd0,
    imm_b = 3'd2
  } imm_type_e;

  // operand 2 mux
  typedef enum logic [1:0] {
    op2_rf  = 2'd0,
    op2_imm = 2'd1,
    op2_csr = 2'd2
  } op2_sel_e;

  // branch kind, resolved in X
  typedef enum logic [1:0] {
    br_none = 2'd0,
    br_bne  = 2'd1,
    br_beq  = 2'd2
  } br_type_e;

  // data memory request
  typedef enum logic [1:0] {
    mem_none = 2'd0,
    mem_load = 2'd1
  } mem_type_e;

  // writeback mux in M
  typedef enum logic {
    wb_alu = 1'b0,
    wb_mem = 1'b1
  } wb_sel_e;

  // next PC source in F
  typedef enum logic [1:0] {
    pc_plus4  = 2'd0,
    pc_branch = 2'd1
  } pc_sel_e;

endpackage

// ==== hdl/inst_decode.sv ====
// D stage instruction decoder
// maps the instruction word onto control fields, purely combinational
`timescale 1ns/1ps
`include "proc_ctrl_defs.svh"

module inst_decode (
  input  logic [`INST_W-1:0]       inst_d,
  output logic                     inst_val,
  output logic                     rs1_en,
  output logic                     rs2_en,
  output logic [`REG_ADDR_W-1:0]   rs1,
  output logic [`REG_ADDR_W-1:0]   rs2,
  output logic [`REG_ADDR_W-1:0]   rd,
  output proc_ctrl_pkg::op2_sel_e  op2_sel_d,
  output proc_ctrl_pkg::imm_type_e imm_type_d,
  output proc_ctrl_pkg::alu_fn_e   alu_fn_d,
  output proc_ctrl_pkg::wb_sel_e   wb_sel_d,
  output proc_ctrl_pkg::mem_type_e mem_type_d,
  output proc_ctrl_pkg::br_type_e  br_type_d,
  output logic                     rf_wen_d,
  output logic                     mngr_rd_d,
  output logic                     mngr_wr_d
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] csr;
  logic        wen;

  // --------------------------------------------------
  // instruction fields
  assign opcode = inst_d[6:0];
  assign rd     = inst_d[11:7];
  assign funct3 = inst_d[14:12];
  assign rs1    = inst_d[19:15];
  assign rs2    = inst_d[24:20];
  assign funct7 = inst_d[31:25];
  assign csr    = inst_d[31:20];

  // --------------------------------------------------
  // control table
  always_comb begin
    // defaults describe an illegal encoding, nothing enabled
    inst_val   = 1'b0;
    rs1_en     = 1'b0;
    rs2_en     = 1'b0;
    op2_sel_d  = proc_ctrl_pkg::op2_rf;
    imm_type_d = proc_ctrl_pkg::imm_i;
    alu_fn_d   = proc_ctrl_pkg::alu_add;
    wb_sel_d   = proc_ctrl_pkg::wb_alu;
    mem_type_d = proc_ctrl_pkg::mem_none;
    br_type_d  = proc_ctrl_pkg::br_none;
    wen        = 1'b0;
    mngr_rd_d  = 1'b0;
    mngr_wr_d  = 1'b0;
    case (opcode)
      `OPC_OP: begin
        // reg-reg, funct7 splits add/sub and srl/sra
        inst_val = 1'b1;
        case ({funct7, funct3})
          {`F7_BASE, `F3_ADD_SUB}: alu_fn_d = proc_ctrl_pkg::alu_add;
          {`F7_ALT,  `F3_ADD_SUB}: alu_fn_d = proc_ctrl_pkg::alu_sub;
          {`F7_BASE, `F3_AND}:     alu_fn_d = proc_ctrl_pkg::alu_and;
          {`F7_BASE, `F3_OR}:      alu_fn_d = proc_ctrl_pkg::alu_or;
          {`F7_BASE, `F3_XOR}:     alu_fn_d = proc_ctrl_pkg::alu_xor;
          {`F7_BASE, `F3_SLT}:     alu_fn_d = proc_ctrl_pkg::alu_slt;
          {`F7_BASE, `F3_SLTU}:    alu_fn_d = proc_ctrl_pkg::alu_sltu;
          {`F7_ALT,  `F3_SRL_SRA}: alu_fn_d = proc_ctrl_pkg::alu_sra;
          {`F7_BASE, `F3_SRL_SRA}: alu_fn_d = proc_ctrl_pkg::alu_srl;
          {`F7_BASE, `F3_SLL}:     alu_fn_d = proc_ctrl_pkg::alu_sll;
          default:                 inst_val = 1'b0;
        endcase
        rs1_en = inst_val;
        rs2_en = inst_val;
        wen    = inst_val;
      end
      `OPC_OP_IMM: begin
        if (inst_d == `INST_NOP) begin
          // nop reads and writes nothing
          inst_val = 1'b1;
        end else if (funct3 == `F3_ADDI) begin
          inst_val  = 1'b1;
          rs1_en    = 1'b1;
          op2_sel_d = proc_ctrl_pkg::op2_imm;
          wen       = 1'b1;
        end
      end
      `OPC_LOAD: begin
        if (funct3 == `F3_LW) begin
          inst_val   = 1'b1;
          rs1_en     = 1'b1;
          op2_sel_d  = proc_ctrl_pkg::op2_imm;
          mem_type_d = proc_ctrl_pkg::mem_load;
          wb_sel_d   = proc_ctrl_pkg::wb_mem;
          wen        = 1'b1;
        end
      end
      `OPC_BRANCH: begin
        // comparison happens in the datapath, we only tag the kind
        inst_val   = (funct3 == `F3_BNE) || (funct3 == `F3_BEQ);
        rs1_en     = inst_val;
        rs2_en     = inst_val;
        imm_type_d = proc_ctrl_pkg::imm_b;
        if (funct3 == `F3_BNE) begin
          br_type_d = proc_ctrl_pkg::br_bne;
        end else if (funct3 == `F3_BEQ) begin
          br_type_d = proc_ctrl_pkg::br_beq;
        end
      end
      `OPC_SYSTEM: begin
        if (funct3 == `F3_CSRRS && csr == `CSR_MNGR2PROC) begin
          // csrr, manager data enters through operand 2
          inst_val  = 1'b1;
          op2_sel_d = proc_ctrl_pkg::op2_csr;
          alu_fn_d  = proc_ctrl_pkg::alu_cp1;
          wen       = 1'b1;
          mngr_rd_d = 1'b1;
        end else if (funct3 == `F3_CSRRW && csr == `CSR_PROC2MNGR) begin
          // csrw, rs1 goes out to the manager in W
          inst_val  = 1'b1;
          rs1_en    = 1'b1;
          alu_fn_d  = proc_ctrl_pkg::alu_cp0;
          mngr_wr_d = 1'b1;
        end
      end
      default: inst_val = 1'b0;
    endcase
  end

  // x0 is never written
  assign rf_wen_d = wen && (rd != '0);

endmodule

// ==== hdl/stage_regs.sv ====
// pipeline state for F through W
// valid bits plus the control fields each stage still needs
`timescale 1ns/1ps
`include "proc_ctrl_defs.svh"

module stage_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     stall_f,
  input  logic                     stall_d,
  input  logic                     stall_x,
  input  logic                     stall_m,
  input  logic                     stall_w,
  input  logic                     squash_f,
  input  logic                     squash_d,
  input  logic                     inst_val,
  input  logic                     rf_wen_d,
  input  logic [`REG_ADDR_W-1:0]   rd,
  input  proc_ctrl_pkg::mem_type_e mem_type_d,
  input  proc_ctrl_pkg::wb_sel_e   wb_sel_d,
  input  proc_ctrl_pkg::br_type_e  br_type_d,
  input  proc_ctrl_pkg::alu_fn_e   alu_fn_d,
  input  logic                     mngr_wr_d,
  output logic                     val_f,
  output logic                     val_d,
  output logic                     val_x,
  output logic                     val_m,
  output logic                     val_w,
  output proc_ctrl_pkg::alu_fn_e   alu_fn_x,
  output proc_ctrl_pkg::br_type_e  br_type_x,
  output proc_ctrl_pkg::mem_type_e mem_type_x,
  output proc_ctrl_pkg::mem_type_e mem_type_m,
  output proc_ctrl_pkg::wb_sel_e   wb_sel_m,
  output logic                     rf_wen_x,
  output logic                     rf_wen_m,
  output logic                     rf_wen_w,
  output logic [`REG_ADDR_W-1:0]   rf_waddr_x,
  output logic [`REG_ADDR_W-1:0]   rf_waddr_m,
  output logic [`REG_ADDR_W-1:0]   rf_waddr_w,
  output logic                     proc2mngr_w
);

  logic                   en_f;
  logic                   en_d;
  logic                   en_x;
  logic                   en_m;
  logic                   en_w;
  logic                   next_val_f;
  logic                   next_val_d;
  logic                   next_val_x;
  logic                   next_val_m;
  proc_ctrl_pkg::wb_sel_e wb_sel_x;
  logic                   proc2mngr_x;
  logic                   proc2mngr_m;
  logic                   rf_wen_pend_w;

  // --------------------------------------------------
  // stage enables, a squash overrides a stall in F and D
  assign en_f = !stall_f || squash_f;
  assign en_d = !stall_d || squash_d;
  assign en_x = !stall_x;
  assign en_m = !stall_m;
  assign en_w = !stall_w;

  // a stalled or squashed stage sends a bubble forward
  assign next_val_f = val_f && !stall_f && !squash_f;
  // illegal encodings die in D
  assign next_val_d = val_d && !stall_d && !squash_d && inst_val;
  assign next_val_x = val_x && !stall_x;
  assign next_val_m = val_m && !stall_m;

  // --------------------------------------------------
  // valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
      val_d <= 1'b0;
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      if (en_f) val_f <= 1'b1;
      if (en_d) val_d <= next_val_f;
      if (en_x) val_x <= next_val_d;
      if (en_m) val_m <= next_val_x;
      if (en_w) val_w <= next_val_m;
    end
  end

  // --------------------------------------------------
  // carried fields, only meaningful while the valid bit is set
  always_ff @(posedge clk) begin
    if (en_x) begin
      alu_fn_x    <= alu_fn_d;
      br_type_x   <= br_type_d;
      mem_type_x  <= mem_type_d;
      wb_sel_x    <= wb_sel_d;
      rf_wen_x    <= rf_wen_d;
      rf_waddr_x  <= rd;
      proc2mngr_x <= mngr_wr_d;
    end
    if (en_m) begin
      mem_type_m  <= mem_type_x;
      wb_sel_m    <= wb_sel_x;
      rf_wen_m    <= rf_wen_x;
      rf_waddr_m  <= rf_waddr_x;
      proc2mngr_m <= proc2mngr_x;
    end
    if (en_w) begin
      rf_wen_pend_w <= rf_wen_m;
      rf_waddr_w    <= rf_waddr_m;
      proc2mngr_w   <= proc2mngr_m;
    end
  end

  // register file write only for a live W instruction
  assign rf_wen_w = val_w && rf_wen_pend_w;

endmodule

// ==== hdl/hazard_unit.sv ====
// stall, squash and branch redirect logic
// also drives every memory and manager strobe
`timescale 1ns/1ps
`include "proc_ctrl_defs.svh"

module hazard_unit (
  input  logic                     reset,
  input  logic                     val_f,
  input  logic                     val_d,
  input  logic                     val_x,
  input  logic                     val_m,
  input  logic                     val_w,
  input  proc_ctrl_pkg::br_type_e  br_type_x,
  input  proc_ctrl_pkg::mem_type_e mem_type_x,
  input  proc_ctrl_pkg::mem_type_e mem_type_m,
  input  logic                     rf_wen_x,
  input  logic                     rf_wen_m,
  input  logic                     rf_wen_w,
  input  logic [`REG_ADDR_W-1:0]   rf_waddr_x,
  input  logic [`REG_ADDR_W-1:0]   rf_waddr_m,
  input  logic [`REG_ADDR_W-1:0]   rf_waddr_w,
  input  logic                     proc2mngr_w,
  input  logic                     rs1_en,
  input  logic                     rs2_en,
  input  logic [`REG_ADDR_W-1:0]   rs1,
  input  logic [`REG_ADDR_W-1:0]   rs2,
  input  logic                     mngr_rd_d,
  input  logic                     br_cond_eq_x,
  input  logic                     imem_respstream_val,
  input  logic                     dmem_reqstream_rdy,
  input  logic                     dmem_respstream_val,
  input  logic                     mngr2proc_val,
  input  logic                     proc2mngr_rdy,
  output logic                     stall_f,
  output logic                     stall_d,
  output logic                     stall_x,
  output logic                     stall_m,
  output logic                     stall_w,
  output logic                     squash_f,
  output logic                     squash_d,
  output logic                     reg_en_f,
  output logic                     reg_en_d,
  output logic                     reg_en_x,
  output logic                     reg_en_m,
  output logic                     reg_en_w,
  output proc_ctrl_pkg::pc_sel_e   pc_sel_f,
  output logic                     imem_reqstream_val,
  output logic                     imem_respstream_rdy,
  output logic                     imem_respstream_drop,
  output logic                     dmem_reqstream_val,
  output logic                     dmem_respstream_rdy,
  output logic                     mngr2proc_rdy,
  output logic                     proc2mngr_val,
  output logic                     commit_inst
);

  logic ostall_f, ostall_d, ostall_x, ostall_m, ostall_w;
  logic hold_f, hold_d, hold_x, hold_m;
  logic wr_x, wr_m, wr_w;
  logic raw_rs1, raw_rs2;
  logic load_x, load_m;
  logic br_taken_x, osquash_x;

  // --------------------------------------------------
  // RAW against every older writer, no bypass paths exist
  assign wr_x = val_x && rf_wen_x;
  assign wr_m = val_m && rf_wen_m;
  assign wr_w = val_w && rf_wen_w;
  assign raw_rs1 = rs1_en && (rs1 != '0) &&
    ((wr_x && rs1 == rf_waddr_x) || (wr_m && rs1 == rf_waddr_m) || (wr_w && rs1 == rf_waddr_w));
  assign raw_rs2 = rs2_en && (rs2 != '0) &&
    ((wr_x && rs2 == rf_waddr_x) || (wr_m && rs2 == rf_waddr_m) || (wr_w && rs2 == rf_waddr_w));

  assign load_x = val_x && (mem_type_x == proc_ctrl_pkg::mem_load);
  assign load_m = val_m && (mem_type_m == proc_ctrl_pkg::mem_load);

  // stall origins per stage
  assign ostall_f = val_f && !imem_respstream_val;
  assign ostall_d = val_d && ((mngr_rd_d && !mngr2proc_val) || raw_rs1 || raw_rs2);
  assign ostall_x = load_x && !dmem_reqstream_rdy;
  assign ostall_m = load_m && !dmem_respstream_val;
  assign ostall_w = val_w && proc2mngr_w && !proc2mngr_rdy;

  // a stall holds its own stage and everything behind it
  assign hold_m  = ostall_m || ostall_w;
  assign hold_x  = ostall_x || hold_m;
  assign hold_d  = ostall_d || hold_x;
  assign hold_f  = ostall_f || hold_d;
  assign stall_w = val_w && ostall_w;
  assign stall_m = val_m && hold_m;
  assign stall_x = val_x && hold_x;
  assign stall_d = val_d && hold_d;
  assign stall_f = val_f && hold_f;

  // --------------------------------------------------
  // branch resolution in X, each kind checked exactly once
  assign br_taken_x = val_x &&
    ((br_type_x == proc_ctrl_pkg::br_bne && !br_cond_eq_x) ||
     (br_type_x == proc_ctrl_pkg::br_beq &&  br_cond_eq_x));
  // squash only once, when the branch actually leaves X
  assign osquash_x = br_taken_x && !stall_x;
  assign squash_f  = val_f && osquash_x;
  assign squash_d  = val_d && osquash_x;
  assign pc_sel_f  = osquash_x ? proc_ctrl_pkg::pc_branch : proc_ctrl_pkg::pc_plus4;

  assign reg_en_f = !stall_f || squash_f;
  assign reg_en_d = !stall_d || squash_d;
  assign reg_en_x = !stall_x;
  assign reg_en_m = !stall_m;
  assign reg_en_w = !stall_w;

  // --------------------------------------------------
  // external strobes
  // fetch request goes out ahead of F, held off while in reset
  assign imem_reqstream_val   = reg_en_f && !reset;
  assign imem_respstream_rdy  = reg_en_f;
  assign imem_respstream_drop = squash_f;
  assign dmem_reqstream_val   = load_x && !stall_x;
  assign dmem_respstream_rdy  = load_m && !stall_m;
  // a squashed csrr must not consume manager data
  assign mngr2proc_rdy        = val_d && mngr_rd_d && !stall_d && !squash_d;
  assign proc2mngr_val        = val_w && proc2mngr_w && !stall_w;
  assign commit_inst          = val_w && !stall_w;

endmodule

// ==== hdl/proc_ctrl.sv ====
// control unit of the five-stage pipeline
// decoder and stage registers side by side, joined by the hazard unit
`timescale 1ns/1ps
`include "proc_ctrl_defs.svh"

module proc_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`INST_W-1:0]       inst_d,
  input  logic                     br_cond_eq_x,
  input  logic                     imem_respstream_val,
  input  logic                     dmem_reqstream_rdy,
  input  logic                     dmem_respstream_val,
  input  logic                     mngr2proc_val,
  input  logic                     proc2mngr_rdy,
  output logic                     imem_reqstream_val,
  output logic                     imem_respstream_rdy,
  output logic                     imem_respstream_drop,
  output logic                     dmem_reqstream_val,
  output logic                     dmem_respstream_rdy,
  output logic                     mngr2proc_rdy,
  output logic                     proc2mngr_val,
  output logic                     reg_en_f,
  output logic                     reg_en_d,
  output logic                     reg_en_x,
  output logic                     reg_en_m,
  output logic                     reg_en_w,
  output proc_ctrl_pkg::pc_sel_e   pc_sel_f,
  output proc_ctrl_pkg::op2_sel_e  op2_sel_d,
  output proc_ctrl_pkg::imm_type_e imm_type_d,
  output proc_ctrl_pkg::alu_fn_e   alu_fn_x,
  output proc_ctrl_pkg::wb_sel_e   wb_sel_m,
  output logic [`REG_ADDR_W-1:0]   rf_waddr_w,
  output logic                     rf_wen_w,
  output logic                     commit_inst
);

  // --------------------------------------------------
  // decoder to hazard unit and stage registers
  logic                     inst_val;
  logic                     rs1_en;
  logic                     rs2_en;
  logic [`REG_ADDR_W-1:0]   rs1;
  logic [`REG_ADDR_W-1:0]   rs2;
  logic [`REG_ADDR_W-1:0]   rd;
  proc_ctrl_pkg::alu_fn_e   alu_fn_d;
  proc_ctrl_pkg::wb_sel_e   wb_sel_d;
  proc_ctrl_pkg::mem_type_e mem_type_d;
  proc_ctrl_pkg::br_type_e  br_type_d;
  logic                     rf_wen_d;
  logic                     mngr_rd_d;
  logic                     mngr_wr_d;

  // hazard unit back to stage registers
  logic stall_f, stall_d, stall_x, stall_m, stall_w;
  logic squash_f, squash_d;

  // stage registers to hazard unit
  logic                     val_f, val_d, val_x, val_m, val_w;
  proc_ctrl_pkg::br_type_e  br_type_x;
  proc_ctrl_pkg::mem_type_e mem_type_x;
  proc_ctrl_pkg::mem_type_e mem_type_m;
  logic                     rf_wen_x;
  logic                     rf_wen_m;
  logic [`REG_ADDR_W-1:0]   rf_waddr_x;
  logic [`REG_ADDR_W-1:0]   rf_waddr_m;
  logic                     proc2mngr_w;

  // --------------------------------------------------
  // port names line up across the three units
  inst_decode i_decode (.*);

  stage_regs i_stage_regs (.*);

  hazard_unit i_hazard (.*);

endmodule

// ==== tb/clk_gen.sv ====
// testbench clock and reset source
// 4 ns clock, reset held over the first 8 rising edges
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // release lines up with the 1 ns input skew of the testbench
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== tb/tb_proc_ctrl.sv ====
// testbench for the pipeline control unit
// random program, shadow pipeline tracking and an in-order commit model
`timescale 1ns/1ps
`include "proc_ctrl_defs.svh"

module tb_proc_ctrl;

  localparam int n_inst = 300;
  localparam int timeout_cycles = n_inst * 20;
  localparam int drain_cycles = 20;
  // instruction kinds of the random program
  localparam int k_nop = 0, k_add = 1, k_sub = 2, k_and = 3, k_or = 4, k_xor = 5;
  localparam int k_slt = 6, k_sltu = 7, k_sra = 8, k_srl = 9, k_sll = 10, k_addi = 11;
  localparam int k_lw = 12, k_bne = 13, k_beq = 14, k_csrr = 15, k_csrw = 16;
  localparam int n_kind = 17;

  logic clk;
  logic reset;
  logic [`INST_W-1:0] inst_d;
  logic br_cond_eq_x;
  logic imem_respstream_val;
  logic dmem_reqstream_rdy;
  logic dmem_respstream_val;
  logic mngr2proc_val;
  logic proc2mngr_rdy;
  logic imem_reqstream_val;
  logic imem_respstream_rdy;
  logic imem_respstream_drop;
  logic dmem_reqstream_val;
  logic dmem_respstream_rdy;
  logic mngr2proc_rdy;
  logic proc2mngr_val;
  logic reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w;
  proc_ctrl_pkg::pc_sel_e   pc_sel_f;
  proc_ctrl_pkg::op2_sel_e  op2_sel_d;
  proc_ctrl_pkg::imm_type_e imm_type_d;
  proc_ctrl_pkg::alu_fn_e   alu_fn_x;
  proc_ctrl_pkg::wb_sel_e   wb_sel_m;
  logic [`REG_ADDR_W-1:0]   rf_waddr_w;
  logic                     rf_wen_w;
  logic                     commit_inst;

  // program and expected commit order
  integer      seed;
  logic [31:0] prog_word [n_inst];
  int          prog_kind [n_inst];
  logic        prog_taken [n_inst];
  int          commit_list [$];
  int          exp_load, exp_csrr, exp_csrw;

  // shadow pipeline, indices into the program
  int   fetch_ptr, f_idx, d_idx, x_idx, alu_idx;
  logic v_f, v_d, alu_chk, d_entered;
  int   inflight [$];
  int   pending [0:31];
  int   cycle, drain, n_commit;
  int   n_dreq, n_dresp, n_p2m, n_m2p;

  clk_gen i_clk_gen (.clk(clk), .reset(reset));

  proc_ctrl i_dut (.*);

  task automatic check_eq(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("mismatch at %0t ns: %s, got %0d expected %0d", $time, what, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  // --------------------------------------------------
  // instruction encoding and decode expectations
  function automatic logic [31:0] make_inst(input int kind, input logic [4:0] rd,
      input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = `F3_ADD_SUB;
    f7 = `F7_BASE;
    case (kind)
      k_sub:  f7 = `F7_ALT;
      k_and:  f3 = `F3_AND;
      k_or:   f3 = `F3_OR;
      k_xor:  f3 = `F3_XOR;
      k_slt:  f3 = `F3_SLT;
      k_sltu: f3 = `F3_SLTU;
      k_srl:  f3 = `F3_SRL_SRA;
      k_sll:  f3 = `F3_SLL;
      k_sra: begin
        f3 = `F3_SRL_SRA;
        f7 = `F7_ALT;
      end
      default: f3 = `F3_ADD_SUB;
    endcase
    case (kind)
      k_nop:   return `INST_NOP;
      k_addi:  return {imm, rs1, `F3_ADDI, rd, `OPC_OP_IMM};
      k_lw:    return {imm, rs1, `F3_LW, rd, `OPC_LOAD};
      k_bne:   return {imm[11:5], rs2, rs1, `F3_BNE, imm[4:0], `OPC_BRANCH};
      k_beq:   return {imm[11:5], rs2, rs1, `F3_BEQ, imm[4:0], `OPC_BRANCH};
      k_csrr:  return {`CSR_MNGR2PROC, 5'd0, `F3_CSRRS, rd, `OPC_SYSTEM};
      k_csrw:  return {`CSR_PROC2MNGR, rs1, `F3_CSRRW, 5'd0, `OPC_SYSTEM};
      default: return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endcase
  endfunction

  // slots past the program end hold an illegal word
  function automatic int kind_at(input int idx);
    return (idx >= 0 && idx < n_inst) ? prog_kind[idx] : -1;
  endfunction

  function automatic logic [31:0] word_at(input int idx);
    return (idx >= 0 && idx < n_inst) ? prog_word[idx] : 32'h0;
  endfunction

  function automatic logic is_rop(input int kind);
    return kind >= k_add && kind <= k_sll;
  endfunction

  function automatic logic is_branch(input int kind);
    return kind == k_bne || kind == k_beq;
  endfunction

  function automatic logic reads_rs1(input int kind);
    return is_rop(kind) || is_branch(kind) || kind == k_addi || kind == k_lw || kind == k_csrw;
  endfunction

  function automatic logic reads_rs2(input int kind);
    return is_rop(kind) || is_branch(kind);
  endfunction

  // register writer with a nonzero destination
  function automatic logic writes_rd(input int idx);
    int k;
    k = prog_kind[idx];
    return (is_rop(k) || k == k_addi || k == k_lw || k == k_csrr) && prog_word[idx][11:7] != 0;
  endfunction

  // -1 marks a field the decode table leaves open
  function automatic int exp_op2(input int kind);
    if (is_rop(kind) || is_branch(kind)) return int'(proc_ctrl_pkg::op2_rf);
    if (kind == k_addi || kind == k_lw) return int'(proc_ctrl_pkg::op2_imm);
    if (kind == k_csrr) return int'(proc_ctrl_pkg::op2_csr);
    return -1;
  endfunction

  function automatic int exp_imm(input int kind);
    if (kind == k_addi || kind == k_lw) return int'(proc_ctrl_pkg::imm_i);
    if (is_branch(kind)) return int'(proc_ctrl_pkg::imm_b);
    return -1;
  endfunction

  function automatic int exp_alu(input int kind);
    case (kind)
      k_add, k_addi, k_lw: return int'(proc_ctrl_pkg::alu_add);
      k_sub:   return int'(proc_ctrl_pkg::alu_sub);
      k_and:   return int'(proc_ctrl_pkg::alu_and);
      k_or:    return int'(proc_ctrl_pkg::alu_or);
      k_xor:   return int'(proc_ctrl_pkg::alu_xor);
      k_slt:   return int'(proc_ctrl_pkg::alu_slt);
      k_sltu:  return int'(proc_ctrl_pkg::alu_sltu);
      k_sra:   return int'(proc_ctrl_pkg::alu_sra);
      k_srl:   return int'(proc_ctrl_pkg::alu_srl);
      k_sll:   return int'(proc_ctrl_pkg::alu_sll);
      k_csrr:  return int'(proc_ctrl_pkg::alu_cp1);
      k_csrw:  return int'(proc_ctrl_pkg::alu_cp0);
      default: return -1;
    endcase
  endfunction

  // --------------------------------------------------
  // random program, then the commit order with two slots dropped per taken branch
  task automatic make_program();
    int i;
    int k;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    for (i = 0; i < n_inst; i++) begin
      k = $unsigned($random(seed)) % n_kind;
      // few registers so that hazards are common
      rd  = 5'($random(seed) & 7);
      rs1 = 5'($random(seed) & 7);
      rs2 = 5'($random(seed) & 7);
      // odd immediate keeps addi apart from the nop word
      imm = 12'($random(seed)) | 12'd1;
      prog_kind[i]  = k;
      prog_taken[i] = 1'($random(seed));
      prog_word[i]  = make_inst(k, rd, rs1, rs2, imm);
    end
    i = 0;
    while (i < n_inst) begin
      commit_list.push_back(i);
      if (prog_kind[i] == k_lw) exp_load++;
      if (prog_kind[i] == k_csrr) exp_csrr++;
      if (prog_kind[i] == k_csrw) exp_csrw++;
      i = (is_branch(prog_kind[i]) && prog_taken[i]) ? i + 3 : i + 1;
    end
  endtask

  // inputs 1 ns after the edge, the branch outcome follows the shadow X slot
  task automatic drive_inputs();
    inst_d = word_at(d_idx);
    if (kind_at(x_idx) == k_beq) begin
      br_cond_eq_x = prog_taken[x_idx];
    end else if (kind_at(x_idx) == k_bne) begin
      br_cond_eq_x = !prog_taken[x_idx];
    end else begin
      br_cond_eq_x = 1'($random(seed));
    end
    imem_respstream_val = ($random(seed) & 3) != 0;
    dmem_reqstream_rdy  = ($random(seed) & 3) != 0;
    dmem_respstream_val = ($random(seed) & 3) != 0;
    mngr2proc_val       = ($random(seed) & 3) != 0;
    proc2mngr_rdy       = ($random(seed) & 3) != 0;
  endtask

  // --------------------------------------------------
  // checks late in the cycle, then the shadow moves as the DUT will at the edge
  task automatic sample_cycle();
    int   k;
    int   ci;
    logic squash;
    logic f_moves;
    logic d_moves;
    if (reset) begin
      check_eq(int'(imem_reqstream_val), 0, "imem request during reset");
      return;
    end
    if (cycle == 0) check_eq(int'(imem_reqstream_val), 1, "imem request after reset");
    if (!d_entered) begin
      check_eq(int'(commit_inst), 0, "commit before any instruction");
      check_eq(int'(rf_wen_w), 0, "rf_wen_w before any instruction");
      check_eq(int'(dmem_reqstream_val), 0, "dmem request before any instruction");
      check_eq(int'(proc2mngr_val), 0, "proc2mngr_val before any instruction");
      check_eq(int'(mngr2proc_rdy), 0, "mngr2proc_rdy before any instruction");
    end
    // decode of whatever sits on inst_d
    k = kind_at(d_idx);
    if (k >= 0 && exp_op2(k) != -1) check_eq(int'(op2_sel_d), exp_op2(k), "op2_sel_d");
    if (k >= 0 && exp_imm(k) != -1) check_eq(int'(imm_type_d), exp_imm(k), "imm_type_d");
    if (alu_chk && exp_alu(kind_at(alu_idx)) != -1) begin
      check_eq(int'(alu_fn_x), exp_alu(kind_at(alu_idx)), "alu_fn_x");
    end
    n_dreq  += int'(dmem_reqstream_val && dmem_reqstream_rdy);
    n_dresp += int'(dmem_respstream_val && dmem_respstream_rdy);
    n_p2m   += int'(proc2mngr_val && proc2mngr_rdy);
    n_m2p   += int'(mngr2proc_val && mngr2proc_rdy);

    squash  = (pc_sel_f == proc_ctrl_pkg::pc_branch);
    // fetch side strobes
    check_eq(int'(imem_respstream_drop), int'(v_f && squash), "imem_respstream_drop");
    check_eq(int'(imem_respstream_rdy), int'(imem_reqstream_val), "imem_respstream_rdy");
    // a load response lands in M and is written back from memory
    if (dmem_respstream_rdy) begin
      check_eq(int'(wb_sel_m), int'(proc_ctrl_pkg::wb_mem), "wb_sel_m for a load");
      check_eq(int'(reg_en_m), 1, "reg_en_m while a load response is taken");
    end
    if (proc2mngr_val) check_eq(int'(reg_en_w), 1, "reg_en_w while proc2mngr is sent");
    if (commit_inst) check_eq(int'(reg_en_w), 1, "reg_en_w at commit");
    f_moves = v_f && reg_en_f && !squash;
    d_moves = v_d && reg_en_d && !squash && k >= 0;
    // an instruction leaving D must not read a register still being written
    if (d_moves) begin
      if (reads_rs1(k) && prog_word[d_idx][19:15] != 0) begin
        check_eq(pending[prog_word[d_idx][19:15]], 0, "rs1 read with an older write pending");
      end
      if (reads_rs2(k) && prog_word[d_idx][24:20] != 0) begin
        check_eq(pending[prog_word[d_idx][24:20]], 0, "rs2 read with an older write pending");
      end
      if (writes_rd(d_idx)) pending[prog_word[d_idx][11:7]]++;
      inflight.push_back(d_idx);
    end
    if (commit_inst) begin
      check_eq(int'(n_commit < commit_list.size()), 1, "commit past the last instruction");
      check_eq(int'(inflight.size() > 0), 1, "commit with no instruction in flight");
      ci = commit_list[n_commit];
      check_eq(inflight.pop_front(), ci, "index of the committed instruction");
      check_eq(int'(rf_wen_w), int'(writes_rd(ci)), "rf_wen_w at commit");
      if (writes_rd(ci)) begin
        check_eq(int'(rf_waddr_w), int'(prog_word[ci][11:7]), "rf_waddr_w at commit");
        pending[prog_word[ci][11:7]]--;
      end
      n_commit++;
    end

    // redirect fetch past the two slots behind the branch
    if (squash) fetch_ptr = x_idx + 3;
    if (reg_en_x) x_idx = d_idx;
    alu_chk = d_moves;
    alu_idx = d_idx;
    if (reg_en_d) begin
      d_idx = f_idx;
      v_d   = f_moves;
      if (f_moves) d_entered = 1'b1;
    end
    if (reg_en_f) begin
      f_idx = fetch_ptr;
      fetch_ptr++;
      v_f = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // main sequence
  initial begin
    int i;
    seed = 10401;
    inst_d = '0;
    br_cond_eq_x = 1'b0;
    imem_respstream_val = 1'b0;
    dmem_reqstream_rdy = 1'b0;
    dmem_respstream_val = 1'b0;
    mngr2proc_val = 1'b0;
    proc2mngr_rdy = 1'b0;
    exp_load = 0;
    exp_csrr = 0;
    exp_csrw = 0;
    for (i = 0; i < 32; i++) pending[i] = 0;
    // empty slots point past the program
    fetch_ptr = 0;
    f_idx = n_inst;
    d_idx = n_inst;
    x_idx = n_inst;
    alu_idx = n_inst;
    v_f = 1'b0;
    v_d = 1'b0;
    alu_chk = 1'b0;
    d_entered = 1'b0;
    cycle = 0;
    drain = 0;
    n_commit = 0;
    n_dreq = 0;
    n_dresp = 0;
    n_p2m = 0;
    n_m2p = 0;
    make_program();

    while (drain < drain_cycles) begin
      @(posedge clk);
      #1;
      drive_inputs();
      #2;
      sample_cycle();
      if (!reset) cycle++;
      // a few idle cycles after the last commit catch stray commits
      if (n_commit == commit_list.size()) drain++;
      if (cycle > timeout_cycles) begin
        $display("timeout: %0d of %0d instructions committed in %0d cycles",
                 n_commit, commit_list.size(), cycle);
        $display("FAIL: see errors above");
        $fatal(1, "run did not finish");
      end
    end

    check_eq(n_commit, commit_list.size(), "number of commits");
    check_eq(n_dreq, exp_load, "dmem request transfers");
    check_eq(n_dresp, exp_load, "dmem response transfers");
    check_eq(n_p2m, exp_csrw, "proc2mngr transfers");
    check_eq(n_m2p, exp_csrr, "mngr2proc transfers");
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/proc_ctrl_pkg.sv
hdl/inst_decode.sv
hdl/stage_regs.sv
hdl/hazard_unit.sv
hdl/proc_ctrl.sv
tb/clk_gen.sv
tb/tb_proc_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the control unit testbench with verilator and run it
# success only when the simulation output holds the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module tb_proc_ctrl -o sim_proc_ctrl &&
./obj_dir/sim_proc_ctrl | tee /dev/stderr | grep "PASS: all tests" > /dev/null &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation failed"; exit 1; }
